// ==== run.sh ====
#!/usr/bin/env bash
# build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cpu -f tb.f -o tb_cpu_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_cpu_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

// ==== source/alu.sv ====
// alu: add, sub, logic ops, logical shifts, pass-through and equality flag
`timescale 1ns/1ns
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    eq
);

    logic [4:0] shamt;

    // only the low five bits count for RV32 shifts
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_PASS_B: begin
                // used by LUI
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // compare flag for BEQ and BNE
    assign eq = (a == b);

endmodule

`default_nettype wire

// ==== source/control_fsm.sv ====
// control_fsm: state machine, instruction register, alu operand select, memory and output handshakes
`timescale 1ns/1ns
`default_nettype none

module control_fsm import cpu_pkg::*; #(
    parameter word_t OUT_ADDR  = 32'd1000,
    parameter word_t HALT_ADDR = 32'd1004
) (
    input  logic           clk,
    input  logic           rst,
    input  decoded_instr_t dec,
    output word_t          instr,
    input  word_t          rs1_data,
    input  word_t          rs2_data,
    output alu_op_e        alu_op,
    output word_t          alu_a,
    output word_t          alu_b,
    input  word_t          alu_result,
    input  logic           alu_eq,
    input  word_t          pc,
    output logic           pc_step,
    output logic           pc_branch,
    output logic           rd_we,
    output reg_sel_t       rd_sel,
    output word_t          rd_data,
    output mem_req_t       mem_req,
    output logic           mem_req_valid,
    input  logic           mem_req_ready,
    input  logic           mem_rsp_valid,
    input  word_t          mem_rsp_data,
    output word_t          out_data,
    output logic           out_valid,
    input  logic           out_ready,
    output logic           halted
);

    state_e state;
    state_e next_state;
    logic   is_store;
    logic   br_taken;
    logic   writes_rd;

    assign is_store  = (dec.opcode == STORE);
    assign br_taken  = (dec.funct3 == F3_BNE) ? !alu_eq : alu_eq;
    assign writes_rd = (dec.opcode == OP) || (dec.opcode == OP_IMM) || (dec.opcode == LUI);

    // operand b is rs2 for OP and BRANCH, otherwise an immediate
    always_comb begin
        alu_a  = rs1_data;
        alu_b  = rs2_data;
        alu_op = ALU_ADD;
        case (dec.opcode)
            OP_IMM, LOAD: begin
                alu_b = dec.imm_i;
            end
            STORE: begin
                alu_b = dec.imm_s;
            end
            LUI: begin
                alu_b  = dec.imm_u;
                alu_op = ALU_PASS_B;
            end
            OP: begin
                case (dec.funct3)
                    F3_ADD:  alu_op = (dec.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SRL:  alu_op = ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: begin
                alu_op = ALU_ADD;
            end
        endcase
    end

    always_comb begin
        next_state = state;
        pc_step    = 1'b0;
        pc_branch  = 1'b0;
        rd_we      = 1'b0;
        case (state)
            RESET_FETCH: next_state = FETCH_REQ;
            FETCH_REQ:   if (mem_req_ready) next_state = FETCH_WAIT;
            FETCH_WAIT:  if (mem_rsp_valid) next_state = EXECUTE;
            EXECUTE: begin
                if (!dec.legal) begin
                    next_state = HALTED;
                end else if (dec.opcode == LOAD) begin
                    next_state = MEM_REQ;
                end else if (is_store) begin
                    // store address is compared against the i/o map first
                    if (alu_result == HALT_ADDR) begin
                        next_state = HALTED;
                    end else if (alu_result == OUT_ADDR) begin
                        next_state = OUT_WAIT;
                    end else begin
                        next_state = MEM_REQ;
                    end
                end else begin
                    next_state = FETCH_REQ;
                    rd_we      = writes_rd;
                    pc_branch  = (dec.opcode == BRANCH) && br_taken;
                    pc_step    = !pc_branch;
                end
            end
            MEM_REQ: if (mem_req_ready) next_state = MEM_WAIT;
            MEM_WAIT: begin
                if (mem_rsp_valid) begin
                    next_state = FETCH_REQ;
                    rd_we      = !is_store;
                    pc_step    = 1'b1;
                end
            end
            OUT_WAIT: begin
                if (out_ready) begin
                    next_state = FETCH_REQ;
                    pc_step    = 1'b1;
                end
            end
            default: next_state = HALTED;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= RESET_FETCH;
            mem_req_valid <= 1'b0;
        end else begin
            state         <= next_state;
            mem_req_valid <= (next_state == FETCH_REQ) || (next_state == MEM_REQ);
        end
    end

    // instruction register, loaded on the fetch response
    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && mem_rsp_valid) begin
            instr <= mem_rsp_data;
        end
    end

    always_comb begin
        mem_req.addr  = pc;
        mem_req.wdata = '0;
        mem_req.we    = 1'b0;
        if (state == MEM_REQ) begin
            mem_req.addr  = alu_result;
            mem_req.wdata = rs2_data;
            mem_req.we    = is_store;
        end
    end

    assign rd_sel    = dec.rd;
    assign rd_data   = (state == MEM_WAIT) ? mem_rsp_data : alu_result;
    assign out_data  = rs2_data;
    assign out_valid = (state == OUT_WAIT);
    assign halted    = (state == HALTED);

    a_req_valid_state: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> (state == FETCH_REQ || state == MEM_REQ));

    // request held while memory back-pressures
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
// shared widths, funct codes, opcode/alu/state enums, memory request and decoded instruction structs
`default_nettype none

package cpu_pkg;

    localparam int XLEN          = 32;
    localparam int REG_SEL_WIDTH = 5;

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [REG_SEL_WIDTH-1:0] reg_sel_t;

    // funct3 codes of the supported instructions
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;

    // funct7 selects SUB against ADD
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        RESET_FETCH,
        FETCH_REQ,
        FETCH_WAIT,
        EXECUTE,
        MEM_REQ,
        MEM_WAIT,
        OUT_WAIT,
        HALTED
    } state_e;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        opcode_e    opcode;
        reg_sel_t   rd;
        reg_sel_t   rs1;
        reg_sel_t   rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        logic       legal;
    } decoded_instr_t;

endpackage

`default_nettype wire

// ==== source/cpu_top.sv ====
// cpu_top: connects control_fsm, instr_decoder, reg_file, alu and pc_counter
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter word_t OUT_ADDR  = 32'd1000,
    parameter word_t HALT_ADDR = 32'd1004,
    parameter word_t RESET_PC  = 32'd0
) (
    input  logic     clk,
    input  logic     rst,
    output mem_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    input  logic     mem_rsp_valid,
    input  word_t    mem_rsp_data,
    output word_t    out_data,
    output logic     out_valid,
    input  logic     out_ready,
    output logic     halted
);

    decoded_instr_t dec;
    word_t          instr;
    word_t          rs1_data;
    word_t          rs2_data;
    alu_op_e        alu_op;
    word_t          alu_a;
    word_t          alu_b;
    word_t          alu_result;
    logic           alu_eq;
    word_t          pc;
    logic           pc_step;
    logic           pc_branch;
    logic           rd_we;
    reg_sel_t       rd_sel;
    word_t          rd_data;

    control_fsm #(
        .OUT_ADDR  (OUT_ADDR),
        .HALT_ADDR (HALT_ADDR)
    ) control_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .dec           (dec),
        .instr         (instr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .alu_op        (alu_op),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_result    (alu_result),
        .alu_eq        (alu_eq),
        .pc            (pc),
        .pc_step       (pc_step),
        .pc_branch     (pc_branch),
        .rd_we         (rd_we),
        .rd_sel        (rd_sel),
        .rd_data       (rd_data),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .halted        (halted)
    );

    instr_decoder instr_decoder_inst (
        .instr (instr),
        .dec   (dec)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (dec.rs1),
        .rs2_sel  (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rd_we),
        .rd_sel   (rd_sel),
        .rd_data  (rd_data)
    );

    alu alu_inst (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .eq     (alu_eq)
    );

    // branch offset is the B immediate of the current instruction
    pc_counter #(
        .RESET_PC (RESET_PC)
    ) pc_counter_inst (
        .clk    (clk),
        .rst    (rst),
        .step   (pc_step),
        .branch (pc_branch),
        .offset (dec.imm_b),
        .pc     (pc)
    );

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
// instr_decoder: field slicing, immediate generation and legality check
`timescale 1ns/1ns
`default_nettype none

module instr_decoder import cpu_pkg::*; (
    input  word_t          instr,
    output decoded_instr_t dec
);

    always_comb begin
        dec.opcode = opcode_e'(instr[6:0]);
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.funct3 = instr[14:12];
        dec.funct7 = instr[31:25];

        // immediates, all sign-extended from bit 31
        dec.imm_i = {{20{instr[31]}}, instr[31:20]};
        dec.imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        dec.imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        dec.imm_u = {instr[31:12], 12'h000};

        case (dec.opcode)
            OP_IMM: dec.legal = (dec.funct3 == F3_ADD);
            LOAD:   dec.legal = (dec.funct3 == F3_LW);
            STORE:  dec.legal = (dec.funct3 == F3_SW);
            BRANCH: dec.legal = (dec.funct3 == F3_BEQ) || (dec.funct3 == F3_BNE);
            LUI:    dec.legal = 1'b1;
            OP: begin
                if (dec.funct7 == F7_SUB) begin
                    dec.legal = (dec.funct3 == F3_ADD);
                end else if (dec.funct7 == F7_BASE) begin
                    dec.legal = (dec.funct3 == F3_ADD) || (dec.funct3 == F3_SLL) ||
                                (dec.funct3 == F3_XOR) || (dec.funct3 == F3_SRL) ||
                                (dec.funct3 == F3_OR)  || (dec.funct3 == F3_AND);
                end else begin
                    dec.legal = 1'b0;
                end
            end
            default: dec.legal = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/pc_counter.sv ====
// pc_counter: program counter with hold, step by four and branch load
`timescale 1ns/1ns
`default_nettype none

module pc_counter import cpu_pkg::*; #(
    parameter word_t RESET_PC = 32'd0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  step,
    input  logic  branch,
    input  word_t offset,
    output word_t pc
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (branch) begin
            pc <= pc + offset;
        end else if (step) begin
            pc <= pc + 32'd4;
        end
    end

    a_step_branch_excl: assert property (@(posedge clk) disable iff (rst)
        !(step && branch));

    // a misaligned branch target would show up here one cycle later
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// reg_file: 32 x 32-bit registers, two async read ports, one write port, x0 hardwired to zero
`timescale 1ns/1ns
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_sel_t rs1_sel,
    input  reg_sel_t rs2_sel,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_sel_t rd_sel,
    input  word_t    rd_data
);

    word_t regs [2**REG_SEL_WIDTH];

    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_SEL_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_sel != '0) begin
            regs[rd_sel] <= rd_data;
        end
    end

    // the FSM must never hand over a write with a floating select
    a_write_sel_known: assert property (@(posedge clk) disable iff (rst)
        we |-> !$isunknown(rd_sel));

endmodule

`default_nettype wire

// ==== tb.f ====
source/cpu_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/pc_counter.sv
source/control_fsm.sv
source/cpu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_memory.sv
testbench/tb_cpu.sv

// ==== testbench/tb_clock_gen.sv ====
// tb_clock_gen: free-running testbench clock
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half period low
    always begin
        #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_cpu.sv ====
// testbench top with program loading, directed tests and summary
`timescale 1ns/1ns
`default_nettype none

module tb_cpu import cpu_pkg::*;;

    localparam int          MEM_WORDS  = 256;
    localparam int unsigned SEED       = 92823;
    localparam int          MAX_CYCLES = 5000;
    localparam int          OUT_ADDR   = 1000;
    localparam int          HALT_ADDR  = 1004;

    logic     clk;
    logic     rst = 1'b1;
    logic     out_ready = 1'b0;
    logic     load_we = 1'b0;
    int       load_idx = 0;
    word_t    load_data = '0;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    logic     mem_rsp_valid;
    word_t    mem_rsp_data;
    word_t    out_data;
    logic     out_valid;
    logic     halted;

    bit          random_ready = 1'b0;
    int unsigned rand_state = SEED;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    word_t       prog[$];
    word_t       got[$];
    word_t       exp_out[$];

    tb_clock_gen #(.PERIOD(100)) tb_clock_gen_inst (.clk(clk));

    tb_memory #(.WORDS(MEM_WORDS), .SEED(SEED)) tb_memory_inst (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data), .load_we(load_we), .load_idx(load_idx),
        .load_data(load_data)
    );

    cpu_top #(.OUT_ADDR(OUT_ADDR), .HALT_ADDR(HALT_ADDR), .RESET_PC(0)) cpu_top_inst (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data), .out_data(out_data), .out_valid(out_valid),
        .out_ready(out_ready), .halted(halted)
    );

    function automatic int unsigned lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // output port back-pressure
    always @(posedge clk) begin
        if (random_ready) begin
            out_ready <= lcg_next() >= 32'h8000_0000;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // small assembler for the supported instructions
    function automatic word_t enc_i(input int op, input int rd, input int f3,
                                    input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t enc_r(input int f7, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t enc_s(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic word_t enc_lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t addi(input int rd, input int rs1, input int imm);
        return enc_i('b0010011, rd, 0, rs1, imm);
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int imm);
        return enc_i('b0000011, rd, 2, rs1, imm);
    endfunction

    function automatic word_t fill_word(input int idx);
        return {8'hc3, idx[23:0]};
    endfunction

    // load the program while the core is stopped and then apply reset
    task automatic run_program();
        int cycles;
        got.delete();
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_idx  <= i;
            load_data <= (i < prog.size()) ? prog[i] : fill_word(i);
        end
        @(posedge clk);
        load_we <= 1'b0;
        rst     <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(negedge clk);
            if (halted) break;
            if (out_valid && out_ready) got.push_back(out_data);
            cycles++;
        end
        assert (halted) else begin
            $display("timeout, the CPU did not halt within %0d cycles", MAX_CYCLES);
            error_count++;
        end
    endtask

    task automatic compare_outputs();
        assert (got.size() == exp_out.size()) else begin
            $display("** Error at %0t ns: %0d outputs, expected %0d", $time, got.size(),
                     exp_out.size());
            error_count++;
        end
        for (int i = 0; i < got.size() && i < exp_out.size(); i++) begin
            assert (got[i] == exp_out[i]) else begin
                $display("** Error at %0t ns: output %0d is %h, expected %h", $time, i,
                         got[i], exp_out[i]);
                error_count++;
            end
        end
    endtask

    // after halt nothing may move on the memory or output port
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (halted && !out_valid && !mem_req_valid) else begin
                $display("** Error at %0t ns: activity after halt", $time);
                error_count++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    task automatic test_alu();
        int    errs;
        word_t a;
        word_t b;
        word_t s;
        errs = error_count;
        a = 100;
        b = -7;
        s = 3;
        prog = {addi(1, 0, 100), addi(2, 0, -7), addi(3, 0, 3),
                enc_r(0, 2, 1, 0, 4), enc_s(4, 0, OUT_ADDR),
                enc_r(32, 2, 1, 0, 4), enc_s(4, 0, OUT_ADDR),
                enc_r(0, 2, 1, 7, 4), enc_s(4, 0, OUT_ADDR),
                enc_r(0, 2, 1, 6, 4), enc_s(4, 0, OUT_ADDR),
                enc_r(0, 2, 1, 4, 4), enc_s(4, 0, OUT_ADDR),
                enc_r(0, 3, 1, 1, 4), enc_s(4, 0, OUT_ADDR),
                enc_r(0, 3, 2, 5, 4), enc_s(4, 0, OUT_ADDR),
                enc_s(0, 0, HALT_ADDR)};
        run_program();
        exp_out = {a + b, a - b, a & b, a | b, a ^ b, a << s[4:0], b >> s[4:0]};
        compare_outputs();
        report_test("alu", errs);
    endtask

    task automatic test_lui();
        int errs;
        errs = error_count;
        prog = {enc_lui(5, 'h12345), addi(5, 5, -16), enc_s(5, 0, OUT_ADDR),
                enc_lui(6, 'habcde), addi(6, 6, 'h7ff), enc_s(6, 0, OUT_ADDR),
                enc_s(0, 0, HALT_ADDR)};
        run_program();
        exp_out = {(word_t'(20'h12345) << 12) + word_t'(-16),
                   (word_t'(20'habcde) << 12) + word_t'(12'h7ff)};
        compare_outputs();
        report_test("lui", errs);
    endtask

    task automatic test_load_store();
        int    errs;
        word_t vals[3];
        errs = error_count;
        vals = '{32'h123, 32'hffff_ffff, 32'h55};
        prog = {addi(1, 0, 'h123), addi(2, 0, -1), addi(3, 0, 'h55),
                enc_s(1, 0, 512), enc_s(2, 0, 516), enc_s(3, 0, 520),
                lw(6, 0, 512), lw(7, 0, 516), lw(8, 0, 520),
                enc_s(6, 0, OUT_ADDR), enc_s(7, 0, OUT_ADDR), enc_s(8, 0, OUT_ADDR),
                enc_r(0, 2, 1, 0, 0), enc_s(0, 0, OUT_ADDR),
                enc_s(0, 0, HALT_ADDR)};
        run_program();
        exp_out = {vals[0], vals[1], vals[2], 32'h0};
        compare_outputs();
        for (int i = 0; i < 3; i++) begin
            assert (tb_memory_inst.mem[128 + i] == vals[i]) else begin
                $display("** Error at %0t ns: memory word %0d is %h, expected %h", $time,
                         128 + i, tb_memory_inst.mem[128 + i], vals[i]);
                error_count++;
            end
        end
        report_test("load_store", errs);
    endtask

    task automatic test_branch();
        int errs;
        errs = error_count;
        prog = {addi(1, 0, 5), addi(2, 0, 'h7bd),
                enc_s(1, 0, OUT_ADDR), addi(1, 1, -1), enc_b(1, 1, 0, -8),
                enc_b(0, 0, 0, 8), enc_s(2, 0, OUT_ADDR),
                addi(3, 0, 42), enc_b(0, 3, 0, 8), enc_s(3, 0, OUT_ADDR),
                enc_s(0, 0, HALT_ADDR)};
        run_program();
        exp_out.delete();
        for (int n = 5; n >= 1; n--) begin
            exp_out.push_back(n);
        end
        exp_out.push_back(42);
        compare_outputs();
        report_test("branch", errs);
    endtask

    task automatic test_halt();
        int    errs;
        word_t acc;
        errs = error_count;
        prog.delete();
        exp_out.delete();
        acc = 11;
        prog.push_back(addi(1, 0, 11));
        for (int k = 1; k <= 6; k++) begin
            prog.push_back(addi(1, 1, k * 3));
            prog.push_back(enc_s(1, 0, OUT_ADDR));
            acc = acc + k * 3;
            exp_out.push_back(acc);
        end
        prog.push_back(enc_s(0, 0, HALT_ADDR));
        prog.push_back(enc_s(1, 0, OUT_ADDR));
        random_ready = 1'b1;
        run_program();
        compare_outputs();
        check_quiet(20);
        random_ready = 1'b0;
        // illegal opcode must stop the core before the next store
        prog = {addi(1, 0, 77), enc_s(1, 0, OUT_ADDR), 32'h0000_007f, enc_s(1, 0, OUT_ADDR),
                enc_s(0, 0, HALT_ADDR)};
        run_program();
        exp_out = {32'd77};
        compare_outputs();
        check_quiet(20);
        report_test("halt", errs);
    endtask

    initial begin
        test_alu();
        test_lui();
        test_load_store();
        test_branch();
        test_halt();
        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_memory.sv ====
// tb_memory: word memory model with random ready and response delays and a load port
`timescale 1ns/1ns
`default_nettype none

module tb_memory import cpu_pkg::*; #(
    parameter int          WORDS = 256,
    parameter int unsigned SEED  = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req,
    input  logic     mem_req_valid,
    output logic     mem_req_ready,
    output logic     mem_rsp_valid,
    output word_t    mem_rsp_data,
    input  logic     load_we,
    input  int       load_idx,
    input  word_t    load_data
);

    localparam int ADDR_BITS = $clog2(WORDS);

    word_t                mem [WORDS];
    int unsigned          lcg_state;
    int unsigned          ready_cnt;
    int unsigned          rsp_cnt;
    logic                 busy;
    word_t                rd_word;
    logic [ADDR_BITS-1:0] idx;

    initial begin
        lcg_state = SEED;
    end

    // delay of 0 to 3 cycles
    function automatic int unsigned draw_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'd3;
    endfunction

    assign idx = mem_req.addr[ADDR_BITS+1:2];

    always @(posedge clk) begin
        if (load_we) begin
            mem[load_idx] <= load_data;
        end else if (!rst && mem_req_valid && mem_req_ready && mem_req.we) begin
            mem[idx] <= mem_req.wdata;
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            mem_rsp_data  <= '0;
            busy          <= 1'b0;
            rsp_cnt       <= 0;
            ready_cnt     <= draw_delay();
        end else begin
            mem_rsp_valid <= 1'b0;
            if (busy) begin
                if (rsp_cnt == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_data  <= rd_word;
                    busy          <= 1'b0;
                end else begin
                    rsp_cnt <= rsp_cnt - 1;
                end
            end else if (mem_req_valid && mem_req_ready) begin
                // request accepted, data read before any write lands
                mem_req_ready <= 1'b0;
                busy          <= 1'b1;
                rd_word       <= mem[idx];
                rsp_cnt       <= draw_delay();
                ready_cnt     <= draw_delay();
            end else if (mem_req_valid) begin
                if (ready_cnt == 0) begin
                    mem_req_ready <= 1'b1;
                end else begin
                    ready_cnt <= ready_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire
